// File: Bender.yml
package:
  name: axi_rd_interconnect

sources:
  - verilog/axi_ic_pkg.sv
  - verilog/rd_route_if.sv
  - verilog/master_port.sv
  - verilog/slave_port.sv
  - verilog/axi_rd_interconnect.sv
  - target: test
    files:
      - dv/axi_rd_checker.sv
      - dv/tb_axi_rd_interconnect.sv

// File: dv/axi_rd_checker.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rd_checker
    import axi_ic_pkg::*;
(
    input wire              i_clk,
    input wire              i_reset,
    input wire [ADDR_W-1:0] i_m1_araddr,
    input wire [ID_W-1:0]   i_m1_arid,
    input wire              i_m1_arvalid,
    input wire              i_m1_arready,
    input wire              i_m1_rvalid,
    input wire [ADDR_W-1:0] i_m2_araddr,
    input wire [ID_W-1:0]   i_m2_arid,
    input wire              i_m2_arvalid,
    input wire              i_m2_arready,
    input wire              i_m2_rvalid,
    input wire [ADDR_W-1:0] i_s1_araddr,
    input wire [ID_W-1:0]   i_s1_arid,
    input wire              i_s1_arvalid,
    input wire              i_s1_arready,
    input wire              i_s1_rvalid,
    input wire              i_s1_rready,
    input wire              i_s1_rlast,
    input wire [ADDR_W-1:0] i_s2_araddr,
    input wire [ID_W-1:0]   i_s2_arid,
    input wire              i_s2_arvalid,
    input wire              i_s2_arready,
    input wire              i_s2_rvalid,
    input wire              i_s2_rready,
    input wire              i_s2_rlast,
    input wire              i_s1_grant_m1,
    input wire              i_s1_grant_m2,
    input wire              i_s2_grant_m1,
    input wire              i_s2_grant_m2
);

    int unsigned fail_count = 0;
    logic        s1_busy;
    logic        s2_busy;
    logic        req_seen;

    // Burst open from AR handshake until the last R handshake
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            s1_busy <= 1'b0;
            s2_busy <= 1'b0;
        end else begin
            if (i_s1_arvalid && i_s1_arready) begin
                s1_busy <= 1'b1;
            end else if (i_s1_rvalid && i_s1_rready && i_s1_rlast) begin
                s1_busy <= 1'b0;
            end
            if (i_s2_arvalid && i_s2_arready) begin
                s2_busy <= 1'b1;
            end else if (i_s2_rvalid && i_s2_rready && i_s2_rlast) begin
                s2_busy <= 1'b0;
            end
        end
    end

    // Set once any master has raised arvalid after reset
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            req_seen <= 1'b0;
        end else if (i_m1_arvalid || i_m2_arvalid) begin
            req_seen <= 1'b1;
        end
    end

    // Accepted AR shows up at the decoded slave, rebased
    property p_route(ar_hs, hit, maddr, mid, s_arvalid, saddr, sid, offset);
        @(posedge i_clk) disable iff (i_reset)
        ar_hs && hit |-> s_arvalid && saddr == maddr - offset && sid == mid;
    endproperty

    // Slave-side AR belongs to the granted master
    property p_owner(s_arvalid, sid, g1, g2, id1, id2);
        @(posedge i_clk) disable iff (i_reset)
        s_arvalid |-> (g1 && sid == id1) || (g2 && sid == id2);
    endproperty

    a_reset_quiet: assert property (@(posedge i_clk)
        ((i_reset && $past(i_reset)) || (!i_reset && !req_seen)) |->
        !i_s1_arvalid && !i_s2_arvalid && !i_m1_rvalid && !i_m2_rvalid &&
        !i_m1_arready && !i_m2_arready)
        else begin fail_count++; $error("outputs active before the first read"); end

    a_m1_s1: assert property (p_route(i_m1_arvalid && i_m1_arready, i_m1_araddr < S1_SPAN,
        i_m1_araddr, i_m1_arid, i_s1_arvalid, i_s1_araddr, i_s1_arid, 32'd0))
        else begin fail_count++; $error("m1 read not routed to slave 1"); end
    a_m1_s2: assert property (p_route(i_m1_arvalid && i_m1_arready, i_m1_araddr >= S1_SPAN,
        i_m1_araddr, i_m1_arid, i_s2_arvalid, i_s2_araddr, i_s2_arid, S1_SPAN))
        else begin fail_count++; $error("m1 read not routed to slave 2"); end
    a_m2_s1: assert property (p_route(i_m2_arvalid && i_m2_arready, i_m2_araddr < S1_SPAN,
        i_m2_araddr, i_m2_arid, i_s1_arvalid, i_s1_araddr, i_s1_arid, 32'd0))
        else begin fail_count++; $error("m2 read not routed to slave 1"); end
    a_m2_s2: assert property (p_route(i_m2_arvalid && i_m2_arready, i_m2_araddr >= S1_SPAN,
        i_m2_araddr, i_m2_arid, i_s2_arvalid, i_s2_araddr, i_s2_arid, S1_SPAN))
        else begin fail_count++; $error("m2 read not routed to slave 2"); end

    a_s1_owner: assert property (p_owner(i_s1_arvalid, i_s1_arid,
        i_s1_grant_m1, i_s1_grant_m2, i_m1_arid, i_m2_arid))
        else begin fail_count++; $error("slave 1 AR from a master without grant"); end
    a_s2_owner: assert property (p_owner(i_s2_arvalid, i_s2_arid,
        i_s2_grant_m1, i_s2_grant_m2, i_m1_arid, i_m2_arid))
        else begin fail_count++; $error("slave 2 AR from a master without grant"); end

    a_s1_one_burst: assert property (@(posedge i_clk) disable iff (i_reset)
        s1_busy |-> !i_s1_arvalid)
        else begin fail_count++; $error("slave 1 saw AR during an open burst"); end
    a_s2_one_burst: assert property (@(posedge i_clk) disable iff (i_reset)
        s2_busy |-> !i_s2_arvalid)
        else begin fail_count++; $error("slave 2 saw AR during an open burst"); end

endmodule

bind axi_rd_interconnect axi_rd_checker u_checker (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_m1_araddr   (i_m1_araddr),
    .i_m1_arid     (i_m1_arid),
    .i_m1_arvalid  (i_m1_arvalid),
    .i_m1_arready  (o_m1_arready),
    .i_m1_rvalid   (o_m1_rvalid),
    .i_m2_araddr   (i_m2_araddr),
    .i_m2_arid     (i_m2_arid),
    .i_m2_arvalid  (i_m2_arvalid),
    .i_m2_arready  (o_m2_arready),
    .i_m2_rvalid   (o_m2_rvalid),
    .i_s1_araddr   (o_s1_araddr),
    .i_s1_arid     (o_s1_arid),
    .i_s1_arvalid  (o_s1_arvalid),
    .i_s1_arready  (i_s1_arready),
    .i_s1_rvalid   (i_s1_rvalid),
    .i_s1_rready   (o_s1_rready),
    .i_s1_rlast    (i_s1_rlast),
    .i_s2_araddr   (o_s2_araddr),
    .i_s2_arid     (o_s2_arid),
    .i_s2_arvalid  (o_s2_arvalid),
    .i_s2_arready  (i_s2_arready),
    .i_s2_rvalid   (i_s2_rvalid),
    .i_s2_rready   (o_s2_rready),
    .i_s2_rlast    (i_s2_rlast),
    .i_s1_grant_m1 (u_s1.grant_m1),
    .i_s1_grant_m2 (u_s1.grant_m2),
    .i_s2_grant_m1 (u_s2.grant_m1),
    .i_s2_grant_m2 (u_s2.grant_m2)
);

`default_nettype wire

// File: dv/tb_axi_rd_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rd_interconnect
    import axi_ic_pkg::*;
();

    localparam int CLK_NS    = 40;
    localparam int SETTLE_NS = 10;
    localparam int NUM_TESTS = 6;
    localparam int WATCH_NS  = NUM_TESTS * 16 * 8 * CLK_NS;

    logic clk;
    logic reset;

    // Index 1 and 2 select master or slave 1 and 2
    logic [2:1][ADDR_W-1:0]  m_araddr;
    logic [2:1][ID_W-1:0]    m_arid;
    logic [2:1][LEN_W-1:0]   m_arlen;
    logic [2:1][SIZE_W-1:0]  m_arsize;
    logic [2:1][BURST_W-1:0] m_arburst;
    logic [2:1]              m_arvalid;
    logic [2:1]              m_rready;
    wire  [2:1]              m_arready;
    wire  [2:1][ID_W-1:0]    m_rid;
    wire  [2:1][DATA_W-1:0]  m_rdata;
    wire  [2:1][RESP_W-1:0]  m_rresp;
    wire  [2:1]              m_rlast;
    wire  [2:1]              m_rvalid;

    wire  [2:1][ADDR_W-1:0]  s_araddr;
    wire  [2:1][ID_W-1:0]    s_arid;
    wire  [2:1][LEN_W-1:0]   s_arlen;
    wire  [2:1][SIZE_W-1:0]  s_arsize;
    wire  [2:1][BURST_W-1:0] s_arburst;
    wire  [2:1]              s_arvalid;
    wire  [2:1]              s_rready;
    logic [2:1]              s_arready;
    logic [2:1][ID_W-1:0]    s_rid;
    logic [2:1][DATA_W-1:0]  s_rdata;
    logic [2:1][RESP_W-1:0]  s_rresp;
    logic [2:1]              s_rlast;
    logic [2:1]              s_rvalid;

    integer seed;
    int     tb_errors;
    int     err_base;
    int     test_count;
    int     tests_failed;

    axi_rd_interconnect dut (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_m1_araddr  (m_araddr[1]),
        .i_m1_arid    (m_arid[1]),
        .i_m1_arlen   (m_arlen[1]),
        .i_m1_arsize  (m_arsize[1]),
        .i_m1_arburst (m_arburst[1]),
        .i_m1_arvalid (m_arvalid[1]),
        .o_m1_arready (m_arready[1]),
        .o_m1_rid     (m_rid[1]),
        .o_m1_rdata   (m_rdata[1]),
        .o_m1_rresp   (m_rresp[1]),
        .o_m1_rlast   (m_rlast[1]),
        .o_m1_rvalid  (m_rvalid[1]),
        .i_m1_rready  (m_rready[1]),
        .i_m2_araddr  (m_araddr[2]),
        .i_m2_arid    (m_arid[2]),
        .i_m2_arlen   (m_arlen[2]),
        .i_m2_arsize  (m_arsize[2]),
        .i_m2_arburst (m_arburst[2]),
        .i_m2_arvalid (m_arvalid[2]),
        .o_m2_arready (m_arready[2]),
        .o_m2_rid     (m_rid[2]),
        .o_m2_rdata   (m_rdata[2]),
        .o_m2_rresp   (m_rresp[2]),
        .o_m2_rlast   (m_rlast[2]),
        .o_m2_rvalid  (m_rvalid[2]),
        .i_m2_rready  (m_rready[2]),
        .o_s1_araddr  (s_araddr[1]),
        .o_s1_arid    (s_arid[1]),
        .o_s1_arlen   (s_arlen[1]),
        .o_s1_arsize  (s_arsize[1]),
        .o_s1_arburst (s_arburst[1]),
        .o_s1_arvalid (s_arvalid[1]),
        .i_s1_arready (s_arready[1]),
        .i_s1_rid     (s_rid[1]),
        .i_s1_rdata   (s_rdata[1]),
        .i_s1_rresp   (s_rresp[1]),
        .i_s1_rlast   (s_rlast[1]),
        .i_s1_rvalid  (s_rvalid[1]),
        .o_s1_rready  (s_rready[1]),
        .o_s2_araddr  (s_araddr[2]),
        .o_s2_arid    (s_arid[2]),
        .o_s2_arlen   (s_arlen[2]),
        .o_s2_arsize  (s_arsize[2]),
        .o_s2_arburst (s_arburst[2]),
        .o_s2_arvalid (s_arvalid[2]),
        .i_s2_arready (s_arready[2]),
        .i_s2_rid     (s_rid[2]),
        .i_s2_rdata   (s_rdata[2]),
        .i_s2_rresp   (s_rresp[2]),
        .i_s2_rlast   (s_rlast[2]),
        .i_s2_rvalid  (s_rvalid[2]),
        .o_s2_rready  (s_rready[2])
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic int total_errors();
        return tb_errors + dut.u_checker.fail_count;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            tb_errors++;
            $display("FAILED at time %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = total_errors() - err_base;
        test_count++;
        if (errs == 0) begin
            $display("Test %0d (%s): ok", test_count, name);
        end else begin
            tests_failed++;
            $display("Test %0d (%s): %0d errors", test_count, name, errs);
        end
        err_base = total_errors();
    endtask

    // Behavioral slave memory, one burst at a time
    task automatic run_slave(input int sn);
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [LEN_W-1:0]  len;
        int                beat;
        forever begin
            #(SETTLE_NS);
            if (!s_arvalid[sn]) begin
                @(negedge clk);
            end else begin
                // AR accepted 0 to 3 cycles late
                repeat (1 + $unsigned($random(seed)) % 4) @(negedge clk);
                s_arready[sn] = 1'b1;
                #(SETTLE_NS);
                addr = s_araddr[sn];
                id   = s_arid[sn];
                len  = s_arlen[sn];
                // Masters always ask for 4-byte INCR bursts
                check_value($sformatf("s%0d_arsize", sn), s_arsize[sn], 3'd2);
                check_value($sformatf("s%0d_arburst", sn), s_arburst[sn], 2'b01);
                @(negedge clk);
                s_arready[sn] = 1'b0;
                for (beat = 0; beat <= len; beat++) begin
                    repeat ($unsigned($random(seed)) % 3) @(negedge clk);
                    s_rvalid[sn] = 1'b1;
                    s_rid[sn]    = id;
                    s_rdata[sn]  = {8'(sn), 24'(addr + beat)};
                    s_rresp[sn]  = 2'b00;
                    s_rlast[sn]  = (beat == len);
                    #(SETTLE_NS);
                    while (!s_rready[sn]) begin
                        @(negedge clk);
                        #(SETTLE_NS);
                    end
                    @(negedge clk);
                    s_rvalid[sn] = 1'b0;
                    s_rlast[sn]  = 1'b0;
                end
            end
        end
    endtask

    // One read burst from a master, checked beat by beat
    task automatic read_burst(input int mn, input logic [ADDR_W-1:0] addr,
                              input logic [ID_W-1:0] id, input logic [LEN_W-1:0] len);
        int                slave;
        logic [ADDR_W-1:0] rel;
        int                beats;
        bit                done;
        slave = (addr < S1_SPAN) ? 1 : 2;
        rel   = (slave == 1) ? addr : addr - S1_SPAN;
        beats = 0;
        done  = 1'b0;
        m_araddr[mn]  = addr;
        m_arid[mn]    = id;
        m_arlen[mn]   = len;
        m_arsize[mn]  = 3'd2;
        m_arburst[mn] = 2'b01;
        m_arvalid[mn] = 1'b1;
        #(SETTLE_NS);
        while (!m_arready[mn]) begin
            @(negedge clk);
            #(SETTLE_NS);
        end
        @(negedge clk);
        m_arvalid[mn] = 1'b0;
        while (!done) begin
            m_rready[mn] = 1'($random(seed));
            #(SETTLE_NS);
            if (m_rvalid[mn] && m_rready[mn]) begin
                check_value($sformatf("m%0d_rid", mn), m_rid[mn], id);
                check_value($sformatf("m%0d_rdata", mn), m_rdata[mn],
                            {8'(slave), 24'(rel + beats)});
                check_value($sformatf("m%0d_rresp", mn), m_rresp[mn], 0);
                check_value($sformatf("m%0d_rlast", mn), m_rlast[mn], beats == len);
                beats++;
                done = m_rlast[mn];
            end
            @(negedge clk);
        end
        m_rready[mn] = 1'b0;
        check_value($sformatf("m%0d beat count", mn), beats, len + 1);
    endtask

    initial begin
        #(WATCH_NS);
        $display("Watchdog expired before the tests finished");
        $display("Verification failed");
        $finish;
    end

    initial begin
        seed         = 986;
        tb_errors    = 0;
        err_base     = 0;
        test_count   = 0;
        tests_failed = 0;
        reset        = 1'b1;
        m_araddr     = '0;
        m_arid       = '0;
        m_arlen      = '0;
        m_arsize     = '0;
        m_arburst    = '0;
        m_arvalid    = '0;
        m_rready     = '0;
        s_arready    = '0;
        s_rid        = '0;
        s_rdata      = '0;
        s_rresp      = '0;
        s_rlast      = '0;
        s_rvalid     = '0;

        repeat (10) @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);
        report_test("reset");

        fork
            run_slave(1);
            run_slave(2);
        join_none

        read_burst(1, 32'h0000_0040, 8'h11, 8'd3);
        read_burst(2, 32'h0000_0100, 8'h21, 8'd1);
        report_test("decode to slave 1");

        read_burst(1, 32'h0000_0280, 8'h12, 8'd3);
        read_burst(2, 32'h0000_03f0, 8'h22, 8'd2);
        report_test("decode and rebase to slave 2");

        read_burst(1, 32'h0000_0010, 8'h13, 8'd15);
        read_burst(2, 32'h0000_0300, 8'h23, 8'd15);
        report_test("bursts with back-pressure");

        // Same slave from both masters at once
        fork
            read_burst(1, 32'h0000_0020, 8'h14, 8'd7);
            read_burst(2, 32'h0000_0060, 8'h24, 8'd7);
        join
        fork
            read_burst(1, 32'h0000_0220, 8'h15, 8'd3);
            read_burst(2, 32'h0000_0240, 8'h25, 8'd3);
        join
        report_test("contention");

        fork
            read_burst(1, 32'h0000_0100, 8'h16, 8'd7);
            read_burst(2, 32'h0000_0400, 8'h26, 8'd7);
        join
        report_test("concurrency");

        $display("Tests run %0d, failed %0d, errors %0d",
                 test_count, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
verilog/axi_ic_pkg.sv
verilog/rd_route_if.sv
verilog/master_port.sv
verilog/slave_port.sv
verilog/axi_rd_interconnect.sv
dv/axi_rd_checker.sv
dv/tb_axi_rd_interconnect.sv

// File: verilog/axi_ic_pkg.sv
`default_nettype none

package axi_ic_pkg;

    // Bus widths
    localparam int ADDR_W  = 32;
    localparam int ID_W    = 8;
    localparam int DATA_W  = 32;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    localparam int NUM_SLAVES = 2;

    // Slave 1 window, also the offset taken off slave 2 addresses
    localparam logic [ADDR_W-1:0] S1_SPAN = 32'h0000_0200;

    // AR payload
    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [ID_W-1:0]    id;
        logic [LEN_W-1:0]   len;
        logic [SIZE_W-1:0]  size;
        logic [BURST_W-1:0] burst;
    } ar_chan_t;

    // R payload
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
        logic              last;
    } r_chan_t;

endpackage

`default_nettype wire

// File: verilog/axi_rd_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rd_interconnect
    import axi_ic_pkg::*;
(
    input  wire                i_clk,
    input  wire                i_reset,

    // Master 1
    input  wire [ADDR_W-1:0]   i_m1_araddr,
    input  wire [ID_W-1:0]     i_m1_arid,
    input  wire [LEN_W-1:0]    i_m1_arlen,
    input  wire [SIZE_W-1:0]   i_m1_arsize,
    input  wire [BURST_W-1:0]  i_m1_arburst,
    input  wire                i_m1_arvalid,
    output logic               o_m1_arready,
    output logic [ID_W-1:0]    o_m1_rid,
    output logic [DATA_W-1:0]  o_m1_rdata,
    output logic [RESP_W-1:0]  o_m1_rresp,
    output logic               o_m1_rlast,
    output logic               o_m1_rvalid,
    input  wire                i_m1_rready,

    // Master 2
    input  wire [ADDR_W-1:0]   i_m2_araddr,
    input  wire [ID_W-1:0]     i_m2_arid,
    input  wire [LEN_W-1:0]    i_m2_arlen,
    input  wire [SIZE_W-1:0]   i_m2_arsize,
    input  wire [BURST_W-1:0]  i_m2_arburst,
    input  wire                i_m2_arvalid,
    output logic               o_m2_arready,
    output logic [ID_W-1:0]    o_m2_rid,
    output logic [DATA_W-1:0]  o_m2_rdata,
    output logic [RESP_W-1:0]  o_m2_rresp,
    output logic               o_m2_rlast,
    output logic               o_m2_rvalid,
    input  wire                i_m2_rready,

    // Slave 1
    output logic [ADDR_W-1:0]  o_s1_araddr,
    output logic [ID_W-1:0]    o_s1_arid,
    output logic [LEN_W-1:0]   o_s1_arlen,
    output logic [SIZE_W-1:0]  o_s1_arsize,
    output logic [BURST_W-1:0] o_s1_arburst,
    output logic               o_s1_arvalid,
    input  wire                i_s1_arready,
    input  wire [ID_W-1:0]     i_s1_rid,
    input  wire [DATA_W-1:0]   i_s1_rdata,
    input  wire [RESP_W-1:0]   i_s1_rresp,
    input  wire                i_s1_rlast,
    input  wire                i_s1_rvalid,
    output logic               o_s1_rready,

    // Slave 2
    output logic [ADDR_W-1:0]  o_s2_araddr,
    output logic [ID_W-1:0]    o_s2_arid,
    output logic [LEN_W-1:0]   o_s2_arlen,
    output logic [SIZE_W-1:0]  o_s2_arsize,
    output logic [BURST_W-1:0] o_s2_arburst,
    output logic               o_s2_arvalid,
    input  wire                i_s2_arready,
    input  wire [ID_W-1:0]     i_s2_rid,
    input  wire [DATA_W-1:0]   i_s2_rdata,
    input  wire [RESP_W-1:0]   i_s2_rresp,
    input  wire                i_s2_rlast,
    input  wire                i_s2_rvalid,
    output logic               o_s2_rready
);

    ar_chan_t m1_ar;
    ar_chan_t m2_ar;
    ar_chan_t s1_ar;
    ar_chan_t s2_ar;
    r_chan_t  m1_r;
    r_chan_t  m2_r;
    r_chan_t  s1_r;
    r_chan_t  s2_r;

    // Pack the plain ports into channel structs
    assign m1_ar = '{i_m1_araddr, i_m1_arid, i_m1_arlen, i_m1_arsize, i_m1_arburst};
    assign m2_ar = '{i_m2_araddr, i_m2_arid, i_m2_arlen, i_m2_arsize, i_m2_arburst};
    assign s1_r  = '{i_s1_rid, i_s1_rdata, i_s1_rresp, i_s1_rlast};
    assign s2_r  = '{i_s2_rid, i_s2_rdata, i_s2_rresp, i_s2_rlast};

    assign {o_m1_rid, o_m1_rdata, o_m1_rresp, o_m1_rlast} = m1_r;
    assign {o_m2_rid, o_m2_rdata, o_m2_rresp, o_m2_rlast} = m2_r;
    assign {o_s1_araddr, o_s1_arid, o_s1_arlen, o_s1_arsize, o_s1_arburst} = s1_ar;
    assign {o_s2_araddr, o_s2_arid, o_s2_arlen, o_s2_arsize, o_s2_arburst} = s2_ar;

    // One route per master and slave pair
    rd_route_if m1_s1_if ();
    rd_route_if m1_s2_if ();
    rd_route_if m2_s1_if ();
    rd_route_if m2_s2_if ();

    master_port u_m1 (
        .i_ar      (m1_ar),
        .i_arvalid (i_m1_arvalid),
        .o_arready (o_m1_arready),
        .o_r       (m1_r),
        .o_rvalid  (o_m1_rvalid),
        .i_rready  (i_m1_rready),
        .to_s1     (m1_s1_if),
        .to_s2     (m1_s2_if)
    );

    master_port u_m2 (
        .i_ar      (m2_ar),
        .i_arvalid (i_m2_arvalid),
        .o_arready (o_m2_arready),
        .o_r       (m2_r),
        .o_rvalid  (o_m2_rvalid),
        .i_rready  (i_m2_rready),
        .to_s1     (m2_s1_if),
        .to_s2     (m2_s2_if)
    );

    slave_port u_s1 (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .from_m1   (m1_s1_if),
        .from_m2   (m2_s1_if),
        .o_ar      (s1_ar),
        .o_arvalid (o_s1_arvalid),
        .i_arready (i_s1_arready),
        .i_r       (s1_r),
        .i_rvalid  (i_s1_rvalid),
        .o_rready  (o_s1_rready)
    );

    slave_port u_s2 (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .from_m1   (m1_s2_if),
        .from_m2   (m2_s2_if),
        .o_ar      (s2_ar),
        .o_arvalid (o_s2_arvalid),
        .i_arready (i_s2_arready),
        .i_r       (s2_r),
        .i_rvalid  (i_s2_rvalid),
        .o_rready  (o_s2_rready)
    );

endmodule

`default_nettype wire

// File: verilog/master_port.sv
`timescale 1ns/1ps
`default_nettype none

module master_port
    import axi_ic_pkg::*;
(
    input  wire ar_chan_t  i_ar,
    input  wire            i_arvalid,
    output logic           o_arready,
    output r_chan_t        o_r,
    output logic           o_rvalid,
    input  wire            i_rready,
    rd_route_if.requester  to_s1,
    rd_route_if.requester  to_s2
);

    logic [NUM_SLAVES-1:0] sel;
    logic [NUM_SLAVES-1:0] grant;
    logic [NUM_SLAVES-1:0] arready;
    logic [NUM_SLAVES-1:0] rvalid;
    r_chan_t               r_s [NUM_SLAVES];
    ar_chan_t              ar_rebased;

    // Address decode, slave 1 owns the low window
    assign sel[0] = (i_ar.addr < S1_SPAN);
    assign sel[1] = ~sel[0];

    // Slave 2 sees addresses relative to its own base
    always_comb begin
        ar_rebased      = i_ar;
        ar_rebased.addr = i_ar.addr - S1_SPAN;
    end

    // Request side, req stays up through the grant
    assign to_s1.req     = (i_arvalid & sel[0]) | grant[0];
    assign to_s1.ar      = i_ar;
    assign to_s1.arvalid = i_arvalid & sel[0];
    assign to_s1.rready  = i_rready & grant[0];

    assign to_s2.req     = (i_arvalid & sel[1]) | grant[1];
    assign to_s2.ar      = ar_rebased;
    assign to_s2.arvalid = i_arvalid & sel[1];
    assign to_s2.rready  = i_rready & grant[1];

    // Gather the return side per slave
    assign grant[0]   = to_s1.grant;
    assign grant[1]   = to_s2.grant;
    assign arready[0] = to_s1.arready;
    assign arready[1] = to_s2.arready;
    assign rvalid[0]  = to_s1.rvalid;
    assign rvalid[1]  = to_s2.rvalid;
    assign r_s[0]     = to_s1.r;
    assign r_s[1]     = to_s2.r;

    // Slaves zero what they return to a master they have not granted,
    // so a plain OR merges the responses
    always_comb begin
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_r       = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            o_arready = o_arready | arready[i];
            o_rvalid  = o_rvalid | rvalid[i];
            o_r       = o_r | r_s[i];
        end
    end

endmodule

`default_nettype wire

// File: verilog/rd_route_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rd_route_if
    import axi_ic_pkg::*;
();

    logic     req;
    ar_chan_t ar;
    logic     arvalid;
    logic     arready;
    r_chan_t  r;
    logic     rvalid;
    logic     rready;
    // High while this master owns the slave
    logic     grant;

    modport requester (
        output req,
        output ar,
        output arvalid,
        output rready,
        input  arready,
        input  r,
        input  rvalid,
        input  grant
    );

    modport target (
        input  req,
        input  ar,
        input  arvalid,
        input  rready,
        output arready,
        output r,
        output rvalid,
        output grant
    );

endinterface

`default_nettype wire

// File: verilog/slave_port.sv
`timescale 1ns/1ps
`default_nettype none

module slave_port
    import axi_ic_pkg::*;
(
    input  wire            i_clk,
    input  wire            i_reset,
    rd_route_if.target     from_m1,
    rd_route_if.target     from_m2,
    output ar_chan_t       o_ar,
    output logic           o_arvalid,
    input  wire            i_arready,
    input  wire r_chan_t   i_r,
    input  wire            i_rvalid,
    output logic           o_rready
);

    typedef enum logic [1:0] {
        OWNER_IDLE = 2'b00,
        OWNER_M1   = 2'b01,
        OWNER_M2   = 2'b10
    } owner_t;

    owner_t owner;
    owner_t owner_next;
    logic   grant_m1;
    logic   grant_m2;
    logic   last_beat;

    assign grant_m1 = (owner == OWNER_M1);
    assign grant_m2 = (owner == OWNER_M2);

    // Burst ends on the handshake of the beat marked last
    assign last_beat = i_rvalid & o_rready & i_r.last;

    // Fixed priority, master 1 first
    always_comb begin
        owner_next = owner;
        case (owner)
            OWNER_IDLE: begin
                if (from_m1.req) begin
                    owner_next = OWNER_M1;
                end else if (from_m2.req) begin
                    owner_next = OWNER_M2;
                end
            end
            OWNER_M1, OWNER_M2: begin
                if (last_beat) begin
                    owner_next = OWNER_IDLE;
                end
            end
            default: owner_next = OWNER_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            owner <= OWNER_IDLE;
        end else begin
            owner <= owner_next;
        end
    end

    // Slave-side AR and rready follow the owner
    always_comb begin
        case (owner)
            OWNER_M1: begin
                o_ar      = from_m1.ar;
                o_arvalid = from_m1.arvalid;
                o_rready  = from_m1.rready;
            end
            OWNER_M2: begin
                o_ar      = from_m2.ar;
                o_arvalid = from_m2.arvalid;
                o_rready  = from_m2.rready;
            end
            default: begin
                o_ar      = '0;
                o_arvalid = 1'b0;
                o_rready  = 1'b0;
            end
        endcase
    end

    // Return path, only the owner sees anything
    assign from_m1.grant   = grant_m1;
    assign from_m1.arready = i_arready & grant_m1;
    assign from_m1.rvalid  = i_rvalid & grant_m1;
    assign from_m1.r       = grant_m1 ? i_r : '0;

    assign from_m2.grant   = grant_m2;
    assign from_m2.arready = i_arready & grant_m2;
    assign from_m2.rvalid  = i_rvalid & grant_m2;
    assign from_m2.r       = grant_m2 ? i_r : '0;

endmodule

`default_nettype wire
